//--- rtl/csr_pkg.sv
package csr_pkg;

    ////////////////////////////////////////
    // widths and base types
    ////////////////////////////////////////

    localparam int xlen       = 32;                 // data width
    localparam int csr_addr_w = 12;                 // csr address width

    typedef logic [xlen-1:0] csr_data_t;

    // machine mode csr map, unknown addresses read zero
    typedef enum logic [csr_addr_w-1:0] {
        csr_mstatus   = 12'h300,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mtval     = 12'h343,
        csr_mip       = 12'h344,
        csr_pmpcfg0   = 12'h3a0,
        csr_pmpcfg1   = 12'h3a1,
        csr_pmpcfg2   = 12'h3a2,
        csr_pmpcfg3   = 12'h3a3,
        csr_pmpaddr0  = 12'h3b0,
        csr_pmpaddr1  = 12'h3b1,
        csr_pmpaddr2  = 12'h3b2,
        csr_pmpaddr3  = 12'h3b3,
        csr_pmpaddr4  = 12'h3b4,
        csr_pmpaddr5  = 12'h3b5,
        csr_pmpaddr6  = 12'h3b6,
        csr_pmpaddr7  = 12'h3b7,
        csr_pmpaddr8  = 12'h3b8,
        csr_pmpaddr9  = 12'h3b9,
        csr_pmpaddr10 = 12'h3ba,
        csr_pmpaddr11 = 12'h3bb,
        csr_pmpaddr12 = 12'h3bc,
        csr_pmpaddr13 = 12'h3bd,
        csr_pmpaddr14 = 12'h3be,
        csr_pmpaddr15 = 12'h3bf
    } csr_addr_e;

    ////////////////////////////////////////
    // trap registers
    ////////////////////////////////////////

    localparam csr_data_t mstatus_reset = 32'h0000_1800;    // mpp = machine
    localparam csr_data_t mtvec_reset   = '0;
    localparam csr_data_t mepc_reset    = '0;
    localparam csr_data_t mcause_reset  = '0;
    localparam csr_data_t mtval_reset   = '0;
    localparam csr_data_t mie_reset     = '0;
    localparam csr_data_t mip_reset     = '0;

    localparam csr_data_t irq_mask = 32'h0000_0888;         // msi, mti, mei only

    localparam int mie_bit  = 3;                            // mstatus.mie
    localparam int mpie_bit = 7;                            // mstatus.mpie
    localparam int msip_bit = 3;
    localparam int mtip_bit = 7;                            // also mie.mtie
    localparam int meip_bit = 11;

    // interrupt sources, index into irq_vec_t
    typedef enum int {msi = 0, mti = 1, mei = 2} irq_src_e;
    typedef logic [2:0] irq_vec_t;

    localparam int irq_sync_depth = 2;                      // sync flops per line

    ////////////////////////////////////////
    // pmp
    ////////////////////////////////////////

    localparam int nb_pmp_region     = 16;
    localparam int pmp_bytes_per_cfg = xlen / 8;            // cfg bytes per pmpcfg reg
    localparam int nb_pmp_cfg        = nb_pmp_region / pmp_bytes_per_cfg;
    localparam int pmp_lock_bit      = 7;                   // L bit in each cfg byte

    typedef logic [7:0] pmp_cfg_byte_t;
    typedef pmp_cfg_byte_t [nb_pmp_region-1:0] pmp_cfg_arr_t;
    typedef csr_data_t [nb_pmp_region-1:0] pmp_addr_arr_t;

endpackage

//--- rtl/csr_bus_if.sv
`timescale 1ns/100ps

// one of these per register bank, driven by the access port
interface csr_bus_if;

    import csr_pkg::*;

    logic      wr_en;       // already gated by freeze
    csr_addr_e wr_addr;
    csr_data_t wr_data;
    csr_addr_e rd_addr;
    csr_data_t rd_data;     // from the bank, valid when rd_hit
    logic      rd_hit;      // bank owns rd_addr

    modport access (
        output wr_en, wr_addr, wr_data, rd_addr,
        input  rd_data, rd_hit
    );

    modport bank (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data, rd_hit
    );

endinterface

//--- rtl/irq_capture.sv
`timescale 1ns/100ps

// async interrupt lines -> one cycle pulse per rising edge
module irq_capture (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::irq_vec_t  irq_in,      // raw lines, async to clk
    output csr_pkg::irq_vec_t  irq_pulse    // one cycle per synced rising edge
);

    import csr_pkg::*;

    for (genvar src = 0; src < $bits(irq_vec_t); src++) begin : g_src

        logic [irq_sync_depth-1:0] sync_q;  // [0] sees the raw line
        logic                      prev_q;  // last synced level

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                sync_q <= '0;
                prev_q <= 1'b0;
            end else begin
                sync_q <= {sync_q[irq_sync_depth-2:0], irq_in[src]};
                prev_q <= sync_q[irq_sync_depth-1];
            end
        end

        // high for one cycle only, a held line gives a single pulse
        assign irq_pulse[src] = sync_q[irq_sync_depth-1] & ~prev_q;

    end

endmodule

//--- rtl/csr_access_port.sv
`timescale 1ns/100ps

// front end for software csr access
// write info is broadcast to both banks, read data comes back from whoever hits
module csr_access_port (
    input  logic                          rst,
    input  logic                          freeze,
    input  logic                          wr_en,
    input  logic [csr_pkg::csr_addr_w-1:0] wr_addr,
    input  csr_pkg::csr_data_t            wr_data,
    input  logic [csr_pkg::csr_addr_w-1:0] rd_addr,
    output csr_pkg::csr_data_t            rd_data,
    csr_bus_if.access                     bus_trap,
    csr_bus_if.access                     bus_pmp
);

    import csr_pkg::*;

    logic      wr_en_g;     // write enable after freeze
    csr_addr_e wr_addr_e;
    csr_addr_e rd_addr_e;

    assign wr_en_g   = wr_en & ~freeze;     // frozen core writes nothing
    assign wr_addr_e = csr_addr_e'(wr_addr);
    assign rd_addr_e = csr_addr_e'(rd_addr);

    ////////////////////////////////////////
    // broadcast to the banks
    ////////////////////////////////////////

    assign bus_trap.wr_en   = wr_en_g;
    assign bus_trap.wr_addr = wr_addr_e;
    assign bus_trap.wr_data = wr_data;
    assign bus_trap.rd_addr = rd_addr_e;

    assign bus_pmp.wr_en    = wr_en_g;
    assign bus_pmp.wr_addr  = wr_addr_e;
    assign bus_pmp.wr_data  = wr_data;
    assign bus_pmp.rd_addr  = rd_addr_e;

    ////////////////////////////////////////
    // read merge
    ////////////////////////////////////////

    // banks own disjoint address ranges so at most one hits
    always_comb begin
        if (rst || freeze) begin
            rd_data = '0;                       // nothing visible in reset or freeze
        end else if (bus_trap.rd_hit) begin
            rd_data = bus_trap.rd_data;
        end else if (bus_pmp.rd_hit) begin
            rd_data = bus_pmp.rd_data;
        end else begin
            rd_data = '0;                       // unknown csr
        end
    end

endmodule

//--- rtl/trap_csr_bank.sv
`timescale 1ns/100ps

// mstatus, mtvec, mepc, mcause, mtval, mie, mip
module trap_csr_bank (
    input  logic               clk,
    input  logic               rst,
    csr_bus_if.bank            bus,
    input  csr_pkg::irq_vec_t  irq_pulse,   // from irq_capture
    input  logic               trap_wr,     // trap writeback from the pipeline
    input  logic               mret,
    input  logic               clr_meip,
    input  csr_pkg::csr_data_t trap_epc,
    input  csr_pkg::csr_data_t trap_cause,
    input  csr_pkg::csr_data_t trap_tval,
    output csr_pkg::csr_data_t mtvec,
    output csr_pkg::csr_data_t mepc,
    output csr_pkg::csr_data_t mstatus,
    output logic               mtie,
    output logic               irq_pending
);

    import csr_pkg::*;

    csr_data_t mcause_q;
    csr_data_t mtval_q;
    csr_data_t mie_q;
    csr_data_t mip_q;
    csr_data_t mip_next;

    // software write strobes
    logic wr_mstatus, wr_mtvec, wr_mepc, wr_mcause, wr_mtval, wr_mie, wr_mip;

    assign wr_mstatus = bus.wr_en && (bus.wr_addr == csr_mstatus);
    assign wr_mtvec   = bus.wr_en && (bus.wr_addr == csr_mtvec);
    assign wr_mepc    = bus.wr_en && (bus.wr_addr == csr_mepc);
    assign wr_mcause  = bus.wr_en && (bus.wr_addr == csr_mcause);
    assign wr_mtval   = bus.wr_en && (bus.wr_addr == csr_mtval);
    assign wr_mie     = bus.wr_en && (bus.wr_addr == csr_mie);
    assign wr_mip     = bus.wr_en && (bus.wr_addr == csr_mip);

    ////////////////////////////////////////
    // mstatus
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus <= mstatus_reset;
        end else if (trap_wr) begin
            mstatus[mpie_bit] <= mstatus[mie_bit];  // stash mie
            mstatus[mie_bit]  <= 1'b0;              // irqs off in handler
        end else if (mret) begin
            mstatus[mie_bit]  <= mstatus[mpie_bit];
            mstatus[mpie_bit] <= 1'b1;
        end else if (wr_mstatus) begin
            mstatus <= bus.wr_data;
        end
    end

    ////////////////////////////////////////
    // vector and trap info
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec    <= mtvec_reset;
            mepc     <= mepc_reset;
            mcause_q <= mcause_reset;
            mtval_q  <= mtval_reset;
            mie_q    <= mie_reset;
        end else begin
            if (wr_mtvec)
                mtvec <= bus.wr_data;
            // trap writeback beats a software write in the same cycle
            if (trap_wr) begin
                mepc     <= trap_epc;
                mcause_q <= trap_cause;
                mtval_q  <= trap_tval;
            end else begin
                if (wr_mepc)   mepc     <= bus.wr_data;
                if (wr_mcause) mcause_q <= bus.wr_data;
                if (wr_mtval)  mtval_q  <= bus.wr_data;
            end
            if (wr_mie)
                mie_q <= bus.wr_data & irq_mask;    // only 3, 7, 11 stick
        end
    end

    ////////////////////////////////////////
    // mip, edge set wins over any clear
    ////////////////////////////////////////

    always_comb begin
        mip_next = mip_q;
        if (wr_mip)
            mip_next = bus.wr_data & irq_mask;      // sw clear path
        if (clr_meip)
            mip_next[meip_bit] = 1'b0;
        if (irq_pulse[msi]) mip_next[msip_bit] = 1'b1;
        if (irq_pulse[mti]) mip_next[mtip_bit] = 1'b1;
        if (irq_pulse[mei]) mip_next[meip_bit] = 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            mip_q <= mip_reset;
        else
            mip_q <= mip_next;
    end

    // interrupt outputs, gated by global enable
    assign mtie        = mstatus[mie_bit] & mie_q[mtip_bit];
    assign irq_pending = mstatus[mie_bit] & (|(mie_q & mip_q));

    // read back
    always_comb begin
        bus.rd_hit  = 1'b1;
        bus.rd_data = '0;
        case (bus.rd_addr)
            csr_mstatus: bus.rd_data = mstatus;
            csr_mtvec:   bus.rd_data = mtvec;
            csr_mepc:    bus.rd_data = mepc;
            csr_mcause:  bus.rd_data = mcause_q;
            csr_mtval:   bus.rd_data = mtval_q;
            csr_mie:     bus.rd_data = mie_q;
            csr_mip:     bus.rd_data = mip_q;
            default:     bus.rd_hit  = 1'b0;    // not ours
        endcase
    end

endmodule

//--- rtl/pmp_csr_bank.sv
`timescale 1ns/100ps

// pmpcfg0..3 and pmpaddr0..15 with per region lock
module pmp_csr_bank (
    input  logic                  clk,
    input  logic                  rst,
    csr_bus_if.bank               bus,
    output csr_pkg::pmp_cfg_arr_t  pmp_cfg,
    output csr_pkg::pmp_addr_arr_t pmp_addr
);

    import csr_pkg::*;

    pmp_cfg_byte_t cfg_q  [nb_pmp_region];    // one byte per region
    csr_data_t     addr_q [nb_pmp_region];

    ////////////////////////////////////////
    // per region registers
    ////////////////////////////////////////

    for (genvar i = 0; i < nb_pmp_region; i++) begin : g_region

        logic [csr_addr_w-1:0] cfg_addr;    // pmpcfg reg holding this byte
        logic [csr_addr_w-1:0] addr_addr;   // matching pmpaddr
        logic                  locked;
        logic                  cfg_wr;
        logic                  addr_wr;

        assign cfg_addr  = csr_pmpcfg0 + csr_addr_w'(i / pmp_bytes_per_cfg);
        assign addr_addr = csr_pmpaddr0 + csr_addr_w'(i);
        assign locked    = cfg_q[i][pmp_lock_bit];

        // each pmpcfg decodes its own address
        assign cfg_wr  = bus.wr_en && (bus.wr_addr == cfg_addr) && !locked;
        assign addr_wr = bus.wr_en && (bus.wr_addr == addr_addr) && !locked;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                cfg_q[i]  <= '0;
                addr_q[i] <= '0;
            end else begin
                if (cfg_wr)     // byte lane inside the 32 bit write
                    cfg_q[i] <= bus.wr_data[(i % pmp_bytes_per_cfg)*8 +: 8];
                if (addr_wr)
                    addr_q[i] <= bus.wr_data;
            end
        end
    end

    // flatten for the outputs
    always_comb begin
        for (int j = 0; j < nb_pmp_region; j++) begin
            pmp_cfg[j]  = cfg_q[j];
            pmp_addr[j] = addr_q[j];
        end
    end

    ////////////////////////////////////////
    // read back
    ////////////////////////////////////////

    always_comb begin
        bus.rd_hit  = 1'b0;
        bus.rd_data = '0;
        for (int r = 0; r < nb_pmp_cfg; r++) begin
            if (bus.rd_addr == csr_pmpcfg0 + csr_addr_w'(r)) begin
                bus.rd_hit  = 1'b1;
                bus.rd_data = pmp_cfg[r*pmp_bytes_per_cfg +: pmp_bytes_per_cfg];
            end
        end
        for (int r = 0; r < nb_pmp_region; r++) begin
            if (bus.rd_addr == csr_pmpaddr0 + csr_addr_w'(r)) begin
                bus.rd_hit  = 1'b1;
                bus.rd_data = addr_q[r];
            end
        end
    end

endmodule

//--- rtl/csr_unit_top.sv
`timescale 1ns/100ps

// machine mode csr unit
module csr_unit_top (
    input  logic                           clk,
    input  logic                           rst,
    // interrupt lines, async
    input  logic                           ext_irq,
    input  logic                           timer_irq,
    input  logic                           sw_irq,
    // software access
    input  logic                           freeze,
    input  logic                           wr_en,
    input  logic [csr_pkg::csr_addr_w-1:0] wr_addr,
    input  csr_pkg::csr_data_t             wr_data,
    input  logic [csr_pkg::csr_addr_w-1:0] rd_addr,
    output csr_pkg::csr_data_t             rd_data,
    // trap writeback
    input  logic                           trap_wr,
    input  logic                           mret,
    input  logic                           clr_meip,
    input  csr_pkg::csr_data_t             trap_epc,
    input  csr_pkg::csr_data_t             trap_cause,
    input  csr_pkg::csr_data_t             trap_tval,
    // to the core
    output csr_pkg::csr_data_t             mtvec,
    output csr_pkg::csr_data_t             mepc,
    output csr_pkg::csr_data_t             mstatus,
    output logic                           mtie,
    output logic                           irq_pending,
    output csr_pkg::pmp_cfg_arr_t          pmp_cfg,
    output csr_pkg::pmp_addr_arr_t         pmp_addr
);

    import csr_pkg::*;

    irq_vec_t irq_pulse;

    csr_bus_if bus_trap ();
    csr_bus_if bus_pmp ();

    ////////////////////////////////////////
    // instances
    ////////////////////////////////////////

    irq_capture u_irq_capture (
        .clk       (clk),
        .rst       (rst),
        .irq_in    ({ext_irq, timer_irq, sw_irq}),  // mei, mti, msi
        .irq_pulse (irq_pulse)
    );

    csr_access_port u_access_port (
        .rst      (rst),
        .freeze   (freeze),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .bus_trap (bus_trap),
        .bus_pmp  (bus_pmp)
    );

    trap_csr_bank u_trap_bank (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus_trap),
        .irq_pulse   (irq_pulse),
        .trap_wr     (trap_wr),
        .mret        (mret),
        .clr_meip    (clr_meip),
        .trap_epc    (trap_epc),
        .trap_cause  (trap_cause),
        .trap_tval   (trap_tval),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mstatus     (mstatus),
        .mtie        (mtie),
        .irq_pending (irq_pending)
    );

    pmp_csr_bank u_pmp_bank (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus_pmp),
        .pmp_cfg  (pmp_cfg),
        .pmp_addr (pmp_addr)
    );

endmodule

//--- dv/csr_unit_tb.sv
`timescale 1ns/100ps

module csr_unit_tb;

    import csr_pkg::*;

    logic          clk;
    logic          rst;
    logic          ext_irq, timer_irq, sw_irq;
    logic          freeze, wr_en, trap_wr, mret, clr_meip;
    logic [11:0]   wr_addr, rd_addr;
    csr_data_t     wr_data, rd_data;
    csr_data_t     trap_epc, trap_cause, trap_tval;
    csr_data_t     mtvec, mepc, mstatus;
    logic          mtie, irq_pending;
    pmp_cfg_arr_t  pmp_cfg;
    pmp_addr_arr_t pmp_addr;

    csr_data_t   lfsr_q = 32'd4;                        // seed
    int          cycles = 0;
    csr_data_t   exp_cfg [4] = '{default: '0};          // model of pmpcfg0..3
    csr_data_t   exp_addr [16] = '{default: '0};        // model of pmpaddr0..15
    logic [11:0] zero_addr [7] = '{12'h304, 12'h305, 12'h341, 12'h342, 12'h343, 12'h344, 12'h7c0};
    logic [11:0] info_addr [3] = '{12'h341, 12'h342, 12'h343};  // mepc, mcause, mtval

    csr_unit_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // galois lfsr, right shift form of x^32+x^22+x^2+x+1
    function automatic csr_data_t lfsr_next(input csr_data_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic csr_data_t rand_word();
        csr_data_t w;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_q[0]};       // one step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
        return w;
    endfunction

    task automatic check_val(input string name, input csr_data_t got, input csr_data_t exp);
        assert (got === exp) else begin
            $display("FAILED %s expected %h got %h", name, exp, got);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // called on a rising edge, returns on the edge that takes the write
    task automatic csr_write(input logic [11:0] addr, input csr_data_t data);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    task automatic read_check(input logic [11:0] addr, input csr_data_t exp, input string name);
        rd_addr <= addr;
        @(negedge clk);                     // comb read settled
        check_val(name, rd_data, exp);
        @(posedge clk);
    endtask

    // poll mip until the bit shows, sync + edge + mip flop is 3 cycles
    task automatic wait_mip_bit(input int b);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        rd_addr <= 12'h344;
        while (!seen && n < 6) begin
            @(negedge clk);
            seen = rd_data[b];
            n++;
            @(posedge clk);
        end
        assert (seen) else begin
            $display("mip bit %0d was not set within 5 cycles of the interrupt edge", b);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////
    // checkers and timeout
    ////////////////////////////////////////

    // frozen unit shows nothing on the read port
    assert property (@(posedge clk) freeze |-> rd_data == '0) else begin
        $display("FAILED rd_data expected %h got %h", 32'h0, rd_data);
        $display("Simulation FAILED");
        $fatal(1);
    end

    assert property (@(posedge clk) rst |-> !mtie && !irq_pending) else begin
        $display("FAILED mtie/irq_pending expected %h got %h", 2'b00, {mtie, irq_pending});
        $display("Simulation FAILED");
        $fatal(1);
    end

    // pmp cfg bytes cleared in reset
    assert property (@(posedge clk) rst |-> pmp_cfg == '0) else begin
        $display("FAILED pmp_cfg expected %h got %h", 128'h0, pmp_cfg);
        $display("Simulation FAILED");
        $fatal(1);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 600) begin    // stimulus runs about 200 cycles
            $display("Run timed out after %0d cycles without finishing", cycles);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        csr_data_t d, epc, cause, tval;
        rst        <= 1'b1;
        {ext_irq, timer_irq, sw_irq} <= 3'b000;
        freeze     <= 1'b0;
        wr_en      <= 1'b0;
        wr_addr    <= '0;
        wr_data    <= '0;
        rd_addr    <= 12'h300;
        trap_wr    <= 1'b0;
        mret       <= 1'b0;
        clr_meip   <= 1'b0;
        trap_epc   <= '0;
        trap_cause <= '0;
        trap_tval  <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_val("rd_data", rd_data, '0);          // hidden during reset
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // reset values
        read_check(12'h300, 32'h1800, "mstatus");
        foreach (zero_addr[i]) read_check(zero_addr[i], '0, "rd_data");
        for (int r = 0; r < 4; r++) read_check(12'h3a0 + 12'(r), '0, "pmpcfg");
        for (int r = 0; r < 16; r++) read_check(12'h3b0 + 12'(r), '0, "pmpaddr");

        // write and read back, then freeze
        d = rand_word();
        csr_write(12'h305, d);
        read_check(12'h305, d, "mtvec");
        freeze <= 1'b1;
        csr_write(12'h305, ~d);                     // dropped
        read_check(12'h305, '0, "rd_data");
        freeze <= 1'b0;
        read_check(12'h305, d, "mtvec");
        check_val("mtvec", mtvec, d);
        foreach (info_addr[i]) begin
            d = rand_word();
            csr_write(info_addr[i], d);
            read_check(info_addr[i], d, "rd_data");
        end
        d = rand_word();
        csr_write(12'h304, d);
        read_check(12'h304, d & 32'h888, "mie");    // only 3, 7, 11 stick
        d = rand_word();
        csr_write(12'h344, d);
        read_check(12'h344, d & 32'h888, "mip");
        csr_write(12'h344, '0);

        // trap entry with a colliding mepc write, then mret
        csr_write(12'h300, 32'h1808);               // mie on, mpie off
        epc   = rand_word();
        cause = rand_word();
        tval  = rand_word();
        trap_epc   <= epc;
        trap_cause <= cause;
        trap_tval  <= tval;
        trap_wr    <= 1'b1;
        csr_write(12'h341, ~epc);                   // loses to the trap
        trap_wr    <= 1'b0;
        read_check(12'h341, epc, "mepc");
        read_check(12'h342, cause, "mcause");
        read_check(12'h343, tval, "mtval");
        read_check(12'h300, 32'h1880, "mstatus");   // mie -> mpie, mie off
        check_val("mstatus", mstatus, 32'h1880);
        check_val("mepc", mepc, epc);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
        read_check(12'h300, 32'h1888, "mstatus");   // mie back, mpie set

        // interrupt capture
        csr_write(12'h304, 32'h888);
        @(negedge clk);
        check_val("mtie", 32'(mtie), 32'h1);
        check_val("irq_pending", 32'(irq_pending), '0);
        @(posedge clk);
        ext_irq <= 1'b1;
        wait_mip_bit(11);
        @(negedge clk);
        check_val("irq_pending", 32'(irq_pending), 32'h1);
        @(posedge clk);
        csr_write(12'h344, '0);
        repeat (6) @(posedge clk);                  // line held, no new edge
        read_check(12'h344, '0, "mip");
        ext_irq <= 1'b0;
        repeat (4) @(posedge clk);
        ext_irq <= 1'b1;
        wait_mip_bit(11);
        clr_meip <= 1'b1;
        @(posedge clk);
        clr_meip <= 1'b0;
        read_check(12'h344, '0, "mip");
        timer_irq <= 1'b1;
        wait_mip_bit(7);
        sw_irq <= 1'b1;
        wait_mip_bit(3);
        read_check(12'h344, 32'h088, "mip");
        csr_write(12'h300, 32'h1800);               // global enable off
        @(negedge clk);
        check_val("mtie", 32'(mtie), '0);
        check_val("irq_pending", 32'(irq_pending), '0);
        @(posedge clk);

        // pmp, lock region 5 = byte 1 of pmpcfg1
        exp_cfg[1] = rand_word() & 32'h7f7f_7f7f;
        csr_write(12'h3a1, exp_cfg[1]);
        read_check(12'h3a0, '0, "pmpcfg0");
        read_check(12'h3a1, exp_cfg[1], "pmpcfg1");
        read_check(12'h3a2, '0, "pmpcfg2");
        exp_addr[5] = rand_word();
        csr_write(12'h3b5, exp_addr[5]);
        exp_cfg[1] = exp_cfg[1] | 32'h0000_8000;
        csr_write(12'h3a1, exp_cfg[1]);
        d = rand_word() & 32'h7f7f_7f7f;
        csr_write(12'h3a1, d);                      // neighbors take it
        exp_cfg[1] = (d & 32'hffff_00ff) | (exp_cfg[1] & 32'h0000_ff00);
        csr_write(12'h3b5, rand_word());            // locked, ignored
        exp_addr[4] = rand_word();
        csr_write(12'h3b4, exp_addr[4]);
        for (int r = 0; r < 4; r++) begin
            read_check(12'h3a0 + 12'(r), exp_cfg[r], "pmpcfg");
            check_val("pmp_cfg", pmp_cfg[r*4 +: 4], exp_cfg[r]);
        end
        for (int r = 0; r < 16; r++) begin
            read_check(12'h3b0 + 12'(r), exp_addr[r], "pmpaddr");
            check_val("pmp_addr", pmp_addr[r], exp_addr[r]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- csr_unit.f
rtl/csr_pkg.sv
rtl/csr_bus_if.sv
rtl/irq_capture.sv
rtl/csr_access_port.sv
rtl/trap_csr_bank.sv
rtl/pmp_csr_bank.sv
rtl/csr_unit_top.sv
dv/csr_unit_tb.sv
